/* common/cnn_pkg.sv */
package cnn_pkg;

    localparam int NUM_FILTERS  = 3;
    localparam int WIN_TAPS     = 9;
    localparam int NUM_CLASSES  = 10;
    localparam int WEIGHT_WORDS = 29;   // highest writable word address
    localparam int SCORE_SHIFT  = 7;

    // weight byte map
    localparam int CONV_BYTES = NUM_FILTERS * WIN_TAPS;   // class weights start here
    localparam int USED_BYTES = CONV_BYTES + NUM_CLASSES * NUM_FILTERS;

    typedef logic signed [7:0]   weight_t;
    typedef logic [WIN_TAPS-1:0] pixel_win_t;   // bit t is tap t
    typedef logic signed [11:0]  win_sum_t;
    typedef logic signed [15:0]  feature_t;
    typedef logic signed [25:0]  score_t;
    typedef logic [3:0]          class_idx_t;

    // valid sits in bit 0, word address above it
    typedef struct packed {
        logic [6:0] weight_addr;
        logic       valid;
    } ctrl_t;

    typedef struct packed {
        weight_t [NUM_FILTERS-1:0][WIN_TAPS-1:0] tap;
    } conv_weights_t;

    typedef struct packed {
        weight_t [NUM_CLASSES-1:0][NUM_FILTERS-1:0] cls;
    } class_weights_t;

    typedef struct packed {
        feature_t [NUM_FILTERS-1:0] feat;
    } feature_vec_t;

endpackage

/* weights/weight_regs.sv */
`timescale 1ns/10ps

module weight_regs (
    input  logic                    clk_i,
    input  logic                    rst,
    input  logic [15:0]             data_i,
    input  cnn_pkg::ctrl_t          ctrl_i,
    output cnn_pkg::conv_weights_t  conv_w_o,
    output cnn_pkg::class_weights_t class_w_o
);
    import cnn_pkg::*;

    weight_t    w_q [USED_BYTES];
    logic       wr_en;
    logic [6:0] lo_idx;
    logic [6:0] hi_idx;

    // weight words only land while no window is on the bus
    assign wr_en = !ctrl_i.valid && (ctrl_i.weight_addr != 7'd0) &&
                   (ctrl_i.weight_addr <= 7'(WEIGHT_WORDS));

    assign lo_idx = {ctrl_i.weight_addr[5:0], 1'b0} - 7'd2;   // byte 2a-2
    assign hi_idx = lo_idx + 7'd1;

    // hi byte of the last word has no slot and falls away
    always_ff @(posedge clk_i) begin
        if (rst) begin
            for (int b = 0; b < USED_BYTES; b++) begin
                w_q[b] <= '0;
            end
        end else if (wr_en) begin
            for (int b = 0; b < USED_BYTES; b++) begin
                if (7'(b) == lo_idx) begin
                    w_q[b] <= data_i[7:0];
                end
                if (7'(b) == hi_idx) begin
                    w_q[b] <= data_i[15:8];
                end
            end
        end
    end

    always_comb begin
        for (int f = 0; f < NUM_FILTERS; f++) begin
            for (int t = 0; t < WIN_TAPS; t++) begin
                conv_w_o.tap[f][t] = w_q[f*WIN_TAPS + t];
            end
        end
        // class c, filter f after the conv block
        for (int c = 0; c < NUM_CLASSES; c++) begin
            for (int f = 0; f < NUM_FILTERS; f++) begin
                class_w_o.cls[c][f] = w_q[CONV_BYTES + c*NUM_FILTERS + f];
            end
        end
    end

    // stray word addresses leave both weight groups as they were
    a_no_stray_write: assert property (@(posedge clk_i) disable iff (rst)
        (!ctrl_i.valid && (ctrl_i.weight_addr > 7'(WEIGHT_WORDS)))
        |=> ({conv_w_o, class_w_o} == $past({conv_w_o, class_w_o})));

endmodule

/* conv/window_conv.sv */
`timescale 1ns/10ps

module window_conv #(
    parameter int NUM_WINDOWS = 10
) (
    input  logic                   clk_i,
    input  logic                   rst,
    input  cnn_pkg::pixel_win_t    win_i,
    input  logic                   win_valid_i,
    input  cnn_pkg::conv_weights_t conv_w_i,
    output cnn_pkg::feature_vec_t  features_o,
    output logic                   feature_valid_o
);
    import cnn_pkg::*;

    localparam int CNT_W = $clog2(NUM_WINDOWS);

    logic [CNT_W-1:0] win_cnt_q;
    logic             frame_end;
    win_sum_t         win_sum_d [NUM_FILTERS];
    win_sum_t         win_sum_q [NUM_FILTERS];
    logic             sum_valid_q;
    logic             sum_last_q;
    feature_t         acc_q [NUM_FILTERS];

    assign frame_end = win_valid_i && (win_cnt_q == CNT_W'(NUM_WINDOWS - 1));

    // binary pixels just pick which weights go into the sum
    always_comb begin
        for (int f = 0; f < NUM_FILTERS; f++) begin
            win_sum_d[f] = '0;
            for (int t = 0; t < WIN_TAPS; t++) begin
                if (win_i[t]) begin
                    win_sum_d[f] = win_sum_d[f] + win_sum_t'($signed(conv_w_i.tap[f][t]));
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        win_sum_q <= win_sum_d;
    end

    always_ff @(posedge clk_i) begin
        if (rst) begin
            win_cnt_q   <= '0;
            sum_valid_q <= 1'b0;
            sum_last_q  <= 1'b0;
        end else begin
            sum_valid_q <= win_valid_i;
            sum_last_q  <= frame_end;
            if (frame_end) begin
                win_cnt_q <= '0;
            end else if (win_valid_i) begin
                win_cnt_q <= win_cnt_q + 1'b1;   // idle cycles don't count
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst) begin
            for (int f = 0; f < NUM_FILTERS; f++) begin
                acc_q[f] <= '0;
            end
            feature_valid_o <= 1'b0;
        end else begin
            feature_valid_o <= sum_last_q;
            if (sum_valid_q) begin
                for (int f = 0; f < NUM_FILTERS; f++) begin
                    // last window restarts the next frame at zero
                    acc_q[f] <= sum_last_q ? '0 : acc_q[f] + feature_t'(win_sum_q[f]);
                end
            end
        end
    end

    // finished frame held until the next one completes
    always_ff @(posedge clk_i) begin
        if (sum_last_q) begin
            for (int f = 0; f < NUM_FILTERS; f++) begin
                features_o.feat[f] <= acc_q[f] + feature_t'(win_sum_q[f]);
            end
        end
    end

    a_cnt_range: assert property (@(posedge clk_i) disable iff (rst)
        int'(win_cnt_q) < NUM_WINDOWS);

endmodule

/* classify/class_argmax.sv */
`timescale 1ns/10ps

module class_argmax (
    input  logic                    clk_i,
    input  logic                    rst,
    input  cnn_pkg::feature_vec_t   features_i,
    input  logic                    feature_valid_i,
    input  cnn_pkg::class_weights_t class_w_i,
    output cnn_pkg::class_idx_t     class_o,
    output logic                    done_o
);
    import cnn_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SCORE,
        REPORT
    } state_t;

    state_t       state_q;
    feature_vec_t feat_q;
    feature_vec_t feat_src;
    class_idx_t   cls_cnt_q;
    score_t       score_raw;
    score_t       score_shr;
    score_t       max_q;
    class_idx_t   max_idx_q;
    logic         start;
    logic         scoring;
    logic         take_max;

    // a new frame can be picked up from IDLE or straight out of REPORT
    assign start   = feature_valid_i && (state_q != SCORE);
    assign scoring = start || (state_q == SCORE);

    // class 0 is scored on the latching edge, from the live features
    assign feat_src = (state_q == SCORE) ? feat_q : features_i;

    always_comb begin
        score_raw = '0;
        for (int f = 0; f < NUM_FILTERS; f++) begin
            score_raw = score_raw + score_t'($signed(feat_src.feat[f])) *
                                    score_t'($signed(class_w_i.cls[cls_cnt_q][f]));
        end
    end

    assign score_shr = score_raw >>> SCORE_SHIFT;   // floors toward -inf

    // strict compare so a tie keeps the lower class
    assign take_max = (cls_cnt_q == '0) || (score_shr > max_q);

    always_ff @(posedge clk_i) begin
        if (rst) begin
            state_q   <= IDLE;
            cls_cnt_q <= '0;
            class_o   <= '0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                SCORE: begin
                    if (cls_cnt_q == class_idx_t'(NUM_CLASSES - 1)) begin
                        state_q   <= REPORT;
                        cls_cnt_q <= '0;
                    end else begin
                        cls_cnt_q <= cls_cnt_q + 1'b1;
                    end
                end
                REPORT: begin
                    class_o <= max_idx_q;
                    done_o  <= 1'b1;
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
            if (start) begin
                state_q   <= SCORE;
                cls_cnt_q <= class_idx_t'(1);   // class 0 done this edge
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            feat_q <= features_i;
        end
        if (scoring && take_max) begin
            max_q     <= score_shr;
            max_idx_q <= cls_cnt_q;
        end
    end

    // conv side must not finish a frame while this one is still scoring
    a_no_overlap: assert property (@(posedge clk_i) disable iff (rst)
        !(feature_valid_i && (state_q == SCORE)));

endmodule

/* logic/cnn_classifier.sv */
`timescale 1ns/10ps

module cnn_classifier #(
    parameter int NUM_WINDOWS = 10
) (
    input  logic                clk_i,
    input  logic                rst,
    input  logic [15:0]         data_i,
    input  cnn_pkg::ctrl_t      ctrl_i,
    output cnn_pkg::class_idx_t class_o,
    output logic                done_o
);
    import cnn_pkg::*;

    pixel_win_t     win;
    logic           win_valid;
    conv_weights_t  conv_w;
    class_weights_t class_w;
    feature_vec_t   features;
    logic           feature_valid;

    // same data word carries pixels or weight bytes
    assign win       = data_i[WIN_TAPS-1:0];
    assign win_valid = ctrl_i.valid;

    weight_regs weight_regs_inst (
        .clk_i     (clk_i),
        .rst       (rst),
        .data_i    (data_i),
        .ctrl_i    (ctrl_i),
        .conv_w_o  (conv_w),
        .class_w_o (class_w)
    );

    window_conv #(
        .NUM_WINDOWS (NUM_WINDOWS)
    ) window_conv_inst (
        .clk_i           (clk_i),
        .rst             (rst),
        .win_i           (win),
        .win_valid_i     (win_valid),
        .conv_w_i        (conv_w),
        .features_o      (features),
        .feature_valid_o (feature_valid)
    );

    class_argmax class_argmax_inst (
        .clk_i           (clk_i),
        .rst             (rst),
        .features_i      (features),
        .feature_valid_i (feature_valid),
        .class_w_i       (class_w),
        .class_o         (class_o),
        .done_o          (done_o)
    );

endmodule

/* verif/cnn_tb_model.svh */
    integer            seed = 32'h349;
    logic [7:0]        img [58];        // byte image for words 1..29, byte 57 unused
    logic signed [7:0] m_w [57];        // model copy of stored weights
    logic [15:0]       frm_data [$];
    logic [6:0]        frm_addr [$];
    bit                frm_gap [$];     // idle cycle before the window
    int                last_win_cyc;

    task automatic tick();
        @(posedge clk_i);
        #1;
    endtask

    task automatic drive_idle();
        data_i = '0;
        ctrl_i = '0;
    endtask

    // byte map: word a holds bytes 2a-2 (low) and 2a-1 (high)
    function automatic void model_write(input int addr, input logic [15:0] word);
        if (addr >= 1 && addr <= 29) begin
            m_w[2*addr-2] = word[7:0];
            if (2*addr-1 < 57) begin
                m_w[2*addr-1] = word[15:8];
            end
        end
    endfunction

    task automatic write_word(input logic [6:0] addr, input logic [15:0] word);
        data_i             = word;
        ctrl_i.weight_addr = addr;
        ctrl_i.valid       = 1'b0;
        tick();
        drive_idle();
        model_write(int'(addr), word);
    endtask

    task automatic load_image();
        for (int a = 1; a <= 29; a++) begin
            write_word(7'(a), {img[2*a-1], img[2*a-2]});
        end
    endtask

    function automatic void make_frame(input bit gaps, input bit addr_noise);
        logic [6:0] addr;
        frm_data.delete();
        frm_addr.delete();
        frm_gap.delete();
        for (int i = 0; i < NUM_WINDOWS; i++) begin
            addr = addr_noise ? 7'(1 + {$random(seed)} % 29) : 7'd0;
            frm_data.push_back(16'($random(seed)));
            frm_addr.push_back(addr);
            frm_gap.push_back(gaps && (($random(seed) & 1) != 0));
        end
    endfunction

    task automatic send_frame();
        foreach (frm_data[i]) begin
            if (frm_gap[i]) begin
                drive_idle();
                tick();
            end
            data_i             = frm_data[i];
            ctrl_i.weight_addr = frm_addr[i];
            ctrl_i.valid       = 1'b1;
            tick();
        end
        last_win_cyc = cycle_cnt;   // edge that took the last window
        drive_idle();
    endtask

    // expected class of the frame held in frm_data
    function automatic int model_class();
        int feat [3];
        int score;
        int best;
        int best_idx;
        for (int f = 0; f < 3; f++) begin
            feat[f] = 0;
        end
        foreach (frm_data[i]) begin
            for (int f = 0; f < 3; f++) begin
                for (int t = 0; t < 9; t++) begin
                    if (frm_data[i][t]) begin
                        feat[f] += m_w[9*f + t];
                    end
                end
            end
        end
        best     = 0;
        best_idx = 0;
        for (int c = 0; c < 10; c++) begin
            score = 0;
            for (int f = 0; f < 3; f++) begin
                score += feat[f] * m_w[27 + 3*c + f];
            end
            score = score >>> 7;   // floor
            if (c == 0 || score > best) begin
                best     = score;
                best_idx = c;
            end
        end
        return best_idx;
    endfunction

/* verif/cnn_tb.sv */
`timescale 1ns/10ps

module cnn_tb;
    import cnn_pkg::*;

    localparam int NUM_WINDOWS  = 10;
    localparam int DONE_LATENCY = 13;   // edges from last window to done
    localparam int WAIT_LIMIT   = 200;

    logic        clk_i;
    logic        rst;
    logic [15:0] data_i;
    ctrl_t       ctrl_i;
    class_idx_t  class_o;
    logic        done_o;

    int         err_cnt;
    int         test_err_base;
    int         tests_ok;
    int         tests_bad;
    int         cycle_cnt = 0;
    class_idx_t done_cls_q [$];
    int         done_cyc_q [$];

    `include "cnn_tb_model.svh"

    cnn_classifier #(
        .NUM_WINDOWS (NUM_WINDOWS)
    ) cnn_classifier_inst (
        .clk_i   (clk_i),
        .rst     (rst),
        .data_i  (data_i),
        .ctrl_i  (ctrl_i),
        .class_o (class_o),
        .done_o  (done_o)
    );

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // collect every done pulse away from the rising edge
    always @(negedge clk_i) begin
        if (done_o === 1'b1) begin
            done_cls_q.push_back(class_o);
            done_cyc_q.push_back(cycle_cnt + 1);   // edge that samples the pulse
        end
    end

    task automatic check_value(input int got, input int exp, input string what);
        assert (got == exp) else begin
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic clear_results();
        done_cls_q.delete();
        done_cyc_q.delete();
    endtask

    task automatic wait_results(input int n);
        int waited;
        waited = 0;
        while (done_cls_q.size() < n && waited < WAIT_LIMIT) begin
            tick();
            waited++;
        end
        if (done_cls_q.size() < n) begin
            $display("Timeout at %0t ns: done never came for result %0d", $time, n);
            err_cnt++;
        end
    endtask

    task automatic run_frame_check(input int exp_cls, input string what);
        clear_results();
        send_frame();
        wait_results(1);
        repeat (3) tick();
        check_value(done_cls_q.size(), 1, "done pulse count");
        if (done_cls_q.size() == 1) begin
            check_value(int'(done_cls_q[0]), exp_cls, what);
            check_value(done_cyc_q[0] - last_win_cyc, DONE_LATENCY, "done latency");
        end
    endtask

    task automatic end_test(input string name);
        if (err_cnt == test_err_base) begin
            tests_ok++;
        end else begin
            tests_bad++;
        end
        $display("test %s finished with %0d errors", name, err_cnt - test_err_base);
    endtask

    task automatic test_reset();
        test_err_base = err_cnt;
        clear_results();
        for (int i = 0; i < 20; i++) begin
            tick();
            assert (done_o === 1'b0) else begin
                $display("Error at %0t ns: done_o high with no input", $time);
                err_cnt++;
            end
        end
        check_value(int'(class_o), 0, "class_o after reset");
        end_test("reset");
    endtask

    task automatic test_random_frame();
        test_err_base = err_cnt;
        for (int b = 0; b < 58; b++) begin
            img[b] = 8'($random(seed));
        end
        load_image();
        make_frame(1'b0, 1'b0);
        run_frame_check(model_class(), "class of random frame");
        end_test("random frame");
    endtask

    task automatic test_ties_floor();
        test_err_base = err_cnt;
        for (int b = 0; b < 58; b++) begin
            img[b] = (b < 27) ? 8'($random(seed)) : 8'd0;
        end
        load_image();
        make_frame(1'b0, 1'b0);
        run_frame_check(0, "class with zero class weights");
        // conv weights of 1 make each feature count set pixels
        for (int b = 0; b < 58; b++) begin
            img[b] = (b < 27) ? 8'd1 : 8'hFB;
        end
        for (int f = 0; f < 3; f++) begin
            img[27 + 21 + f] = 8'd10;   // only class 7 positive
        end
        load_image();
        foreach (frm_data[i]) begin
            frm_data[i] = 16'h01FF;
        end
        run_frame_check(7, "class with one positive score");
        // with 64 pixels raw -256 and -192 both floor to -2
        for (int c = 0; c < 10; c++) begin
            img[27 + 3*c] = 8'hFF;
            img[28 + 3*c] = 8'hFF;
            img[29 + 3*c] = (c == 9) ? 8'hFF : 8'hFE;
        end
        load_image();
        foreach (frm_data[i]) begin
            frm_data[i] = (i < 4) ? 16'h01FF : ((i < 8) ? 16'h007F : 16'h0000);
        end
        run_frame_check(0, "class with equal negative scores");
        end_test("ties and floor");
    endtask

    task automatic test_ignored_writes();
        test_err_base = err_cnt;
        for (int b = 0; b < 58; b++) begin
            img[b] = 8'($random(seed));
        end
        load_image();
        write_word(7'd0, 16'($random(seed)));
        write_word(7'd30, 16'($random(seed)));
        write_word(7'd65, 16'($random(seed)));   // low six bits point at word 1
        make_frame(1'b0, 1'b1);   // windows carry in-range addresses
        run_frame_check(model_class(), "class after ignored writes");
        end_test("ignored writes");
    endtask

    task automatic test_back_to_back();
        int exp_cls [3];
        test_err_base = err_cnt;
        clear_results();
        for (int k = 0; k < 3; k++) begin
            make_frame(k == 2, 1'b0);   // third frame has idle cycles
            exp_cls[k] = model_class();
            send_frame();
        end
        wait_results(3);
        repeat (3) tick();
        check_value(done_cls_q.size(), 3, "done pulse count");
        for (int k = 0; k < 3 && k < done_cls_q.size(); k++) begin
            check_value(int'(done_cls_q[k]), exp_cls[k], "class in frame order");
        end
        end_test("back-to-back frames");
    endtask

    initial begin
        clk_i     = 1'b0;
        rst       = 1'b1;
        data_i    = '0;
        ctrl_i    = '0;
        err_cnt   = 0;
        tests_ok  = 0;
        tests_bad = 0;
        foreach (m_w[i]) begin
            m_w[i] = '0;
        end
        repeat (2) @(posedge clk_i);
        #1;
        rst = 1'b0;
        test_reset();
        test_random_frame();
        test_ties_floor();
        test_ignored_writes();
        test_back_to_back();
        $display("tests passed: %0d, tests failed: %0d", tests_ok, tests_bad);
        if (err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* cnn_classifier.f */
+incdir+verif
common/cnn_pkg.sv
weights/weight_regs.sv
conv/window_conv.sv
classify/class_argmax.sv
logic/cnn_classifier.sv
verif/cnn_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cnn_classifier testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal --top-module cnn_tb \
    -f cnn_classifier.f -o cnn_sim > "$LOG" 2>&1 &&
    ./obj_dir/cnn_sim >> "$LOG" 2>&1 ||
    echo "Something failed" >> "$LOG"

if grep -q "Something failed" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi
echo "simulation passed"
exit 0
